// ==== axis_csum_pkg.sv ====
// ----------------------------------------
// Byte and checksum types, combiner state,
// default register settings
// ----------------------------------------
package axis_csum_pkg;

    // One stream byte per beat
    typedef logic [7:0] byte_t;

    // Frame checksum, modulo 256
    typedef logic [7:0] csum_t;

    // Combiner: forwarding frame bytes, or trailer pending
    typedef enum logic {
        APPEND_DATA,
        APPEND_CSUM
    } append_state_t;

    // 0 bypass, 1 simple buffer, 2 skid buffer
    localparam int REG_TYPE_DEFAULT = 2;

    // Register stages in the delay path
    localparam int LENGTH_DEFAULT = 2;

endpackage

// ==== axis_register.sv ====
// ----------------------------------------
// AXI-stream register slice, bypass,
// simple buffer or skid buffer
// ----------------------------------------
module axis_register #(
    parameter int REG_TYPE = axis_csum_pkg::REG_TYPE_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  axis_csum_pkg::byte_t s_axis_tdata,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  logic                s_axis_tlast,
    output axis_csum_pkg::byte_t m_axis_tdata,
    output logic                m_axis_tvalid,
    input  logic                m_axis_tready,
    output logic                m_axis_tlast
);
    import axis_csum_pkg::*;

    if (REG_TYPE > 1) begin : g_skid
        // Output register plus temp register for the skid beat
        logic  m_valid_reg;
        byte_t m_data_reg;
        logic  m_last_reg;
        logic  temp_valid_reg;
        byte_t temp_data_reg;
        logic  temp_last_reg;
        logic  s_ready_reg;
        logic  m_valid_next;
        logic  temp_valid_next;
        logic  s_ready_early;
        logic  store_in_to_out;
        logic  store_in_to_temp;
        logic  store_temp_to_out;

        // Ready next cycle if the output drains, or temp stays empty
        assign s_ready_early = m_axis_tready ||
                               (!temp_valid_reg && (!m_valid_reg || !s_axis_tvalid));

        always_comb begin
            m_valid_next      = m_valid_reg;
            temp_valid_next   = temp_valid_reg;
            store_in_to_out   = 1'b0;
            store_in_to_temp  = 1'b0;
            store_temp_to_out = 1'b0;
            if (s_ready_reg) begin
                if (m_axis_tready || !m_valid_reg) begin
                    // Output free, load it straight from the input
                    m_valid_next    = s_axis_tvalid;
                    store_in_to_out = 1'b1;
                end else begin
                    // Output stalled, park the beat in temp
                    temp_valid_next  = s_axis_tvalid;
                    store_in_to_temp = 1'b1;
                end
            end else if (m_axis_tready) begin
                // Input held off, drain temp into output
                m_valid_next      = temp_valid_reg;
                temp_valid_next   = 1'b0;
                store_temp_to_out = 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                m_valid_reg    <= 1'b0;
                temp_valid_reg <= 1'b0;
                s_ready_reg    <= 1'b0;
            end else begin
                m_valid_reg    <= m_valid_next;
                temp_valid_reg <= temp_valid_next;
                s_ready_reg    <= s_ready_early;
            end
            // Payload moves
            if (store_in_to_out) begin
                m_data_reg <= s_axis_tdata;
                m_last_reg <= s_axis_tlast;
            end else if (store_temp_to_out) begin
                m_data_reg <= temp_data_reg;
                m_last_reg <= temp_last_reg;
            end
            if (store_in_to_temp) begin
                temp_data_reg <= s_axis_tdata;
                temp_last_reg <= s_axis_tlast;
            end
        end

        assign s_axis_tready = s_ready_reg;
        assign m_axis_tdata  = m_data_reg;
        assign m_axis_tvalid = m_valid_reg;
        assign m_axis_tlast  = m_last_reg;
    end else if (REG_TYPE == 1) begin : g_simple
        // Single register, takes a beat when empty or draining
        logic  m_valid_reg;
        byte_t m_data_reg;
        logic  m_last_reg;

        assign s_axis_tready = !m_valid_reg || m_axis_tready;

        always_ff @(posedge clk) begin
            if (rst) begin
                m_valid_reg <= 1'b0;
            end else if (s_axis_tready) begin
                m_valid_reg <= s_axis_tvalid;
            end
            if (s_axis_tvalid && s_axis_tready) begin
                m_data_reg <= s_axis_tdata;
                m_last_reg <= s_axis_tlast;
            end
        end

        assign m_axis_tdata  = m_data_reg;
        assign m_axis_tvalid = m_valid_reg;
        assign m_axis_tlast  = m_last_reg;
    end else begin : g_bypass
        // No storage at all
        assign s_axis_tready = m_axis_tready;
        assign m_axis_tdata  = s_axis_tdata;
        assign m_axis_tvalid = s_axis_tvalid;
        assign m_axis_tlast  = s_axis_tlast;
    end

endmodule

// ==== axis_pipeline_register.sv ====
// ----------------------------------------
// Chain of register slices, delay path
// ----------------------------------------
module axis_pipeline_register #(
    parameter int REG_TYPE = axis_csum_pkg::REG_TYPE_DEFAULT,
    parameter int LENGTH   = axis_csum_pkg::LENGTH_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  axis_csum_pkg::byte_t s_axis_tdata,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  logic                s_axis_tlast,
    output axis_csum_pkg::byte_t m_axis_tdata,
    output logic                m_axis_tvalid,
    input  logic                m_axis_tready,
    output logic                m_axis_tlast
);
    import axis_csum_pkg::*;

    // Stage links, index 0 is the input side
    byte_t axis_tdata  [0:LENGTH];
    logic  axis_tvalid [0:LENGTH];
    logic  axis_tready [0:LENGTH];
    logic  axis_tlast  [0:LENGTH];

    assign axis_tdata[0]  = s_axis_tdata;
    assign axis_tvalid[0] = s_axis_tvalid;
    assign axis_tlast[0]  = s_axis_tlast;
    assign s_axis_tready  = axis_tready[0];

    // Last link drives the outputs
    assign m_axis_tdata        = axis_tdata[LENGTH];
    assign m_axis_tvalid       = axis_tvalid[LENGTH];
    assign m_axis_tlast        = axis_tlast[LENGTH];
    assign axis_tready[LENGTH] = m_axis_tready;

    for (genvar i = 0; i < LENGTH; i++) begin : g_stage
        axis_register #(
            .REG_TYPE(REG_TYPE)
        ) reg_inst (
            .clk          (clk),
            .rst          (rst),
            .s_axis_tdata (axis_tdata[i]),
            .s_axis_tvalid(axis_tvalid[i]),
            .s_axis_tready(axis_tready[i]),
            .s_axis_tlast (axis_tlast[i]),
            .m_axis_tdata (axis_tdata[i+1]),
            .m_axis_tvalid(axis_tvalid[i+1]),
            .m_axis_tready(axis_tready[i+1]),
            .m_axis_tlast (axis_tlast[i+1])
        );
    end

endmodule

// ==== axis_broadcast.sv ====
// ----------------------------------------
// Two-way stream splitter with taken flags
// ----------------------------------------
module axis_broadcast (
    input  logic                clk,
    input  logic                rst,
    input  axis_csum_pkg::byte_t s_axis_tdata,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  logic                s_axis_tlast,
    output axis_csum_pkg::byte_t a_axis_tdata,
    output logic                a_axis_tvalid,
    input  logic                a_axis_tready,
    output logic                a_axis_tlast,
    output axis_csum_pkg::byte_t b_axis_tdata,
    output logic                b_axis_tvalid,
    input  logic                b_axis_tready,
    output logic                b_axis_tlast
);

    // Set once an output has the current beat
    logic a_taken;
    logic b_taken;
    logic s_xfer;

    // Same beat to both sides
    assign a_axis_tdata = s_axis_tdata;
    assign a_axis_tlast = s_axis_tlast;
    assign b_axis_tdata = s_axis_tdata;
    assign b_axis_tlast = s_axis_tlast;

    // Withdraw valid on a side that already took the beat
    assign a_axis_tvalid = s_axis_tvalid && !a_taken;
    assign b_axis_tvalid = s_axis_tvalid && !b_taken;

    // Input completes once each side has it or takes it now
    assign s_axis_tready = (a_axis_tready || a_taken) && (b_axis_tready || b_taken);
    assign s_xfer        = s_axis_tvalid && s_axis_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_taken <= 1'b0;
            b_taken <= 1'b0;
        end else if (s_xfer) begin
            // Beat done, start fresh
            a_taken <= 1'b0;
            b_taken <= 1'b0;
        end else begin
            if (a_axis_tvalid && a_axis_tready) begin
                a_taken <= 1'b1;
            end
            if (b_axis_tvalid && b_axis_tready) begin
                b_taken <= 1'b1;
            end
        end
    end

endmodule

// ==== axis_frame_csum.sv ====
// ----------------------------------------
// Per-frame byte sum, one result per frame
// ----------------------------------------
module axis_frame_csum (
    input  logic                clk,
    input  logic                rst,
    input  axis_csum_pkg::byte_t s_axis_tdata,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  logic                s_axis_tlast,
    output axis_csum_pkg::csum_t m_axis_tdata,
    output logic                m_axis_tvalid,
    input  logic                m_axis_tready
);
    import axis_csum_pkg::*;

    csum_t acc;
    csum_t sum_next;
    logic  s_xfer;

    // Only a new last beat needs the result register free
    assign s_axis_tready = !m_axis_tvalid || m_axis_tready || !s_axis_tlast;
    assign s_xfer        = s_axis_tvalid && s_axis_tready;

    // Running sum including the current byte
    assign sum_next = acc + csum_t'(s_axis_tdata);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc           <= '0;
            m_axis_tvalid <= 1'b0;
        end else begin
            if (m_axis_tvalid && m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
            end
            if (s_xfer) begin
                if (s_axis_tlast) begin
                    // Frame done, result out and restart
                    acc           <= '0;
                    m_axis_tvalid <= 1'b1;
                end else begin
                    acc <= sum_next;
                end
            end
        end
        // Two's complement so the frame plus trailer sums to zero
        if (s_xfer && s_axis_tlast) begin
            m_axis_tdata <= ~sum_next + csum_t'(1);
        end
    end

endmodule

// ==== axis_csum_append.sv ====
// ----------------------------------------
// Frame forwarder with checksum trailer
// ----------------------------------------
module axis_csum_append (
    input  logic                clk,
    input  logic                rst,
    input  axis_csum_pkg::byte_t d_axis_tdata,
    input  logic                d_axis_tvalid,
    output logic                d_axis_tready,
    input  logic                d_axis_tlast,
    input  axis_csum_pkg::csum_t c_axis_tdata,
    input  logic                c_axis_tvalid,
    output logic                c_axis_tready,
    output axis_csum_pkg::byte_t m_axis_tdata,
    output logic                m_axis_tvalid,
    input  logic                m_axis_tready,
    output logic                m_axis_tlast
);
    import axis_csum_pkg::*;

    append_state_t state;
    logic          in_data;

    assign in_data = (state == APPEND_DATA);

    // Only the selected source sees ready
    assign d_axis_tready = in_data && m_axis_tready;
    assign c_axis_tready = !in_data && m_axis_tready;

    // Frame bytes with tlast low, then the trailer with tlast high
    always_comb begin
        if (in_data) begin
            m_axis_tdata  = d_axis_tdata;
            m_axis_tvalid = d_axis_tvalid;
        end else begin
            m_axis_tdata  = byte_t'(c_axis_tdata);
            m_axis_tvalid = c_axis_tvalid;
        end
    end

    assign m_axis_tlast = !in_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= APPEND_DATA;
        end else begin
            case (state)
                APPEND_DATA: begin
                    // Last frame byte gone, trailer next
                    if (d_axis_tvalid && d_axis_tready && d_axis_tlast) begin
                        state <= APPEND_CSUM;
                    end
                end
                APPEND_CSUM: begin
                    if (c_axis_tvalid && c_axis_tready) begin
                        state <= APPEND_DATA;
                    end
                end
                default: state <= APPEND_DATA;
            endcase
        end
    end

endmodule

// ==== axis_csum_top.sv ====
// ----------------------------------------
// Checksum trailer unit, splitter, delay
// path, sum path and combiner
// ----------------------------------------
module axis_csum_top #(
    parameter int REG_TYPE = axis_csum_pkg::REG_TYPE_DEFAULT,
    parameter int LENGTH   = axis_csum_pkg::LENGTH_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  axis_csum_pkg::byte_t s_axis_tdata,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  logic                s_axis_tlast,
    output axis_csum_pkg::byte_t m_axis_tdata,
    output logic                m_axis_tvalid,
    input  logic                m_axis_tready,
    output logic                m_axis_tlast
);
    import axis_csum_pkg::*;

    // Splitter to delay path
    byte_t bc_data_tdata;
    logic  bc_data_tvalid;
    logic  bc_data_tready;
    logic  bc_data_tlast;
    // Splitter to sum path
    byte_t bc_sum_tdata;
    logic  bc_sum_tvalid;
    logic  bc_sum_tready;
    logic  bc_sum_tlast;
    // Delayed frame bytes
    byte_t dly_tdata;
    logic  dly_tvalid;
    logic  dly_tready;
    logic  dly_tlast;
    // One checksum per frame, no tlast
    csum_t sum_tdata;
    logic  sum_tvalid;
    logic  sum_tready;

    axis_broadcast axis_broadcast_inst (
        .clk          (clk),
        .rst          (rst),
        .s_axis_tdata (s_axis_tdata),
        .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .s_axis_tlast (s_axis_tlast),
        .a_axis_tdata (bc_data_tdata),
        .a_axis_tvalid(bc_data_tvalid),
        .a_axis_tready(bc_data_tready),
        .a_axis_tlast (bc_data_tlast),
        .b_axis_tdata (bc_sum_tdata),
        .b_axis_tvalid(bc_sum_tvalid),
        .b_axis_tready(bc_sum_tready),
        .b_axis_tlast (bc_sum_tlast)
    );

    axis_pipeline_register #(
        .REG_TYPE(REG_TYPE),
        .LENGTH  (LENGTH)
    ) axis_pipeline_register_inst (
        .clk          (clk),
        .rst          (rst),
        .s_axis_tdata (bc_data_tdata),
        .s_axis_tvalid(bc_data_tvalid),
        .s_axis_tready(bc_data_tready),
        .s_axis_tlast (bc_data_tlast),
        .m_axis_tdata (dly_tdata),
        .m_axis_tvalid(dly_tvalid),
        .m_axis_tready(dly_tready),
        .m_axis_tlast (dly_tlast)
    );

    axis_frame_csum axis_frame_csum_inst (
        .clk          (clk),
        .rst          (rst),
        .s_axis_tdata (bc_sum_tdata),
        .s_axis_tvalid(bc_sum_tvalid),
        .s_axis_tready(bc_sum_tready),
        .s_axis_tlast (bc_sum_tlast),
        .m_axis_tdata (sum_tdata),
        .m_axis_tvalid(sum_tvalid),
        .m_axis_tready(sum_tready)
    );

    axis_csum_append axis_csum_append_inst (
        .clk          (clk),
        .rst          (rst),
        .d_axis_tdata (dly_tdata),
        .d_axis_tvalid(dly_tvalid),
        .d_axis_tready(dly_tready),
        .d_axis_tlast (dly_tlast),
        .c_axis_tdata (sum_tdata),
        .c_axis_tvalid(sum_tvalid),
        .c_axis_tready(sum_tready),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready),
        .m_axis_tlast (m_axis_tlast)
    );

endmodule

// ==== tb_axis_csum.sv ====
// ----------------------------------------
// Testbench for the checksum trailer unit,
// reference queue, checks and watchdog
// ----------------------------------------
module tb_axis_csum;
    timeunit 1ns;
    timeprecision 1ps;
    import axis_csum_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_FRAMES   = 20;
    localparam int          MAX_LEN      = 16;
    localparam int          STALL_CYCLES = 40;
    localparam int unsigned SEED         = 32'hd433_8fbc;

    logic  clk = 1'b0;
    logic  rst;
    byte_t s_axis_tdata;
    logic  s_axis_tvalid;
    logic  s_axis_tready;
    logic  s_axis_tlast;
    byte_t m_axis_tdata;
    logic  m_axis_tvalid;
    logic  m_axis_tready;
    logic  m_axis_tlast;

    // Frame store, last slot is the fixed 5-byte frame
    int    frame_len  [NUM_FRAMES + 1];
    byte_t frame_data [NUM_FRAMES + 1][MAX_LEN];

    // Expected output beats, bit 8 is tlast
    logic [8:0] exp_q [$];
    logic [8:0] exp_beat;

    // Output monitor state
    logic  held_valid = 1'b0;
    byte_t held_data;
    logic  held_last;
    byte_t out_sum = '0;
    int    mon_errors = 0;
    int    stall_block_cycles = 0;

    // Stimulus side
    int    seq_errors = 0;
    int    tests_ok = 0;
    int    tests_bad = 0;
    int    errors_at_start = 0;
    int    sent_bytes = 0;
    int    stall_at = -1;
    int    stall_requests = 0;
    logic  ready_random = 1'b0;
    logic  stall_active = 1'b0;
    int    cycle_limit = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    axis_csum_top axis_csum_top_inst (
        .clk          (clk),
        .rst          (rst),
        .s_axis_tdata (s_axis_tdata),
        .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .s_axis_tlast (s_axis_tlast),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready),
        .m_axis_tlast (m_axis_tlast)
    );

    function automatic void show_mismatch(input string name, input int expected, input int actual);
        $display("Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    endfunction

    // Sink, steady, random or a long stall on request
    initial begin : ready_driver
        int stall_served;
        int stall_left;
        stall_served  = 0;
        stall_left    = 0;
        m_axis_tready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (stall_left == 0 && stall_requests > stall_served) begin
                stall_served++;
                stall_left = STALL_CYCLES;
            end
            if (stall_left > 0) begin
                stall_left--;
                stall_active  = 1'b1;
                m_axis_tready = 1'b0;
            end else begin
                stall_active  = 1'b0;
                m_axis_tready = ready_random ? ($urandom_range(0, 1) == 1) : 1'b1;
            end
        end
    end

    // Outputs are sampled mid-cycle, a transfer follows on the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            held_valid = 1'b0;
            out_sum    = '0;
        end else begin
            // A stalled beat must stay put
            if (held_valid) begin
                assert (m_axis_tvalid) else begin
                    $display("Error at %0t: m_axis_tvalid dropped before its beat was taken",
                             $time);
                    mon_errors++;
                end
                assert (m_axis_tdata == held_data) else begin
                    show_mismatch("m_axis_tdata", int'(held_data), int'(m_axis_tdata));
                    mon_errors++;
                end
                assert (m_axis_tlast == held_last) else begin
                    show_mismatch("m_axis_tlast", int'(held_last), int'(m_axis_tlast));
                    mon_errors++;
                end
            end
            if (m_axis_tvalid && m_axis_tready) begin
                assert (exp_q.size() != 0) else begin
                    $display("Error at %0t: output beat with no byte outstanding", $time);
                    mon_errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_beat = exp_q.pop_front();
                    assert (m_axis_tdata == exp_beat[7:0]) else begin
                        show_mismatch("m_axis_tdata", int'(exp_beat[7:0]), int'(m_axis_tdata));
                        mon_errors++;
                    end
                    assert (m_axis_tlast == exp_beat[8]) else begin
                        show_mismatch("m_axis_tlast", int'(exp_beat[8]), int'(m_axis_tlast));
                        mon_errors++;
                    end
                end
                // Whole frame plus trailer wraps to zero
                out_sum = out_sum + m_axis_tdata;
                if (m_axis_tlast) begin
                    assert (out_sum == 8'h00) else begin
                        show_mismatch("frame byte sum", 0, int'(out_sum));
                        mon_errors++;
                    end
                    out_sum = '0;
                end
            end
            held_valid = m_axis_tvalid && !m_axis_tready;
            held_data  = m_axis_tdata;
            held_last  = m_axis_tlast;
            if (stall_active && s_axis_tvalid && !s_axis_tready) begin
                stall_block_cycles++;
            end
        end
    end

    // Ready is sampled mid-cycle, so the rising edge that follows decides the transfer
    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = s_axis_tready;
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic send_frame(input int f, input logic gaps);
        int i;
        int sum;
        sum = 0;
        // Reference beats, frame bytes then the negated byte sum
        for (i = 0; i < frame_len[f]; i++) begin
            sum = (sum + int'(frame_data[f][i])) % 256;
            exp_q.push_back({1'b0, frame_data[f][i]});
        end
        exp_q.push_back({1'b1, 8'((256 - sum) % 256)});
        for (i = 0; i < frame_len[f]; i++) begin
            if (gaps && $urandom_range(0, 3) == 0) begin
                s_axis_tvalid = 1'b0;
                repeat ($urandom_range(1, 3)) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end
            s_axis_tdata  = frame_data[f][i];
            s_axis_tlast  = (i == frame_len[f] - 1);
            s_axis_tvalid = 1'b1;
            sent_bytes++;
            if (sent_bytes == stall_at) begin
                stall_requests++;
            end
            wait_accept();
        end
    endtask

    task automatic send_frames(input logic gaps);
        int f;
        for (f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f, gaps);
        end
    endtask

    task automatic drain();
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Idle a little so a stray extra beat gets caught
        repeat (6) @(negedge clk);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_idle_valid();
        @(negedge clk);
        assert (m_axis_tvalid === 1'b0) else begin
            show_mismatch("m_axis_tvalid", 0, int'(m_axis_tvalid));
            seq_errors++;
        end
    endtask

    task automatic check_reset();
        int i;
        for (i = 0; i < RESET_CYCLES; i++) begin
            check_idle_valid();
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        // No input yet, nothing may come out
        for (i = 0; i < 8; i++) begin
            check_idle_valid();
        end
        assert (s_axis_tready === 1'b1) else begin
            show_mismatch("s_axis_tready", 1, int'(s_axis_tready));
            seq_errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic begin_test();
        errors_at_start = mon_errors + seq_errors;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = mon_errors + seq_errors - errors_at_start;
        if (errs == 0) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errs);
        end
    endtask

    initial begin : main_flow
        int total_bytes;
        int blocked_before;
        int f;
        int i;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(SEED));
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;

        // Random traffic, two one-byte frames forced in
        total_bytes = 0;
        for (f = 0; f < NUM_FRAMES; f++) begin
            if (f == 5 || f == 6) begin
                frame_len[f] = 1;
            end else begin
                frame_len[f] = $urandom_range(1, MAX_LEN);
            end
            for (i = 0; i < MAX_LEN; i++) begin
                frame_data[f][i] = byte_t'($urandom);
            end
            total_bytes += frame_len[f];
        end
        frame_len[NUM_FRAMES]     = 5;
        frame_data[NUM_FRAMES][0] = 8'h12;
        frame_data[NUM_FRAMES][1] = 8'h34;
        frame_data[NUM_FRAMES][2] = 8'h56;
        frame_data[NUM_FRAMES][3] = 8'hab;
        frame_data[NUM_FRAMES][4] = 8'hff;
        // Random set is replayed four times
        cycle_limit = (4 * total_bytes + frame_len[NUM_FRAMES]) * 4 + 2000;

        begin_test();
        check_reset();
        end_test("reset_idle");

        begin_test();
        send_frame(NUM_FRAMES, 1'b0);
        drain();
        end_test("single_frame");

        begin_test();
        send_frames(1'b0);
        drain();
        end_test("back_to_back");

        ready_random = 1'b1;
        begin_test();
        send_frames(1'b0);
        drain();
        end_test("random_ready");

        begin_test();
        send_frames(1'b1);
        drain();
        end_test("input_gaps");

        // Output held off for a while, ten bytes into the stream
        ready_random = 1'b0;
        begin_test();
        blocked_before = stall_block_cycles;
        stall_at       = sent_bytes + 10;
        send_frames(1'b0);
        drain();
        assert (stall_block_cycles > blocked_before) else begin
            $display("Error at %0t: s_axis_tready never went low during the output stall",
                     $time);
            seq_errors++;
        end
        end_test("long_stall");

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, mon_errors + seq_errors);
        if (tests_bad == 0 && mon_errors + seq_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Limit scales with the traffic length
    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not end within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
axis_csum_pkg.sv
axis_register.sv
axis_pipeline_register.sv
axis_broadcast.sv
axis_frame_csum.sv
axis_csum_append.sv
axis_csum_top.sv
tb_axis_csum.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the checksum trailer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_axis_csum -o tb_axis_csum
./obj_dir/tb_axis_csum > sim.log 2>&1
cat sim.log
if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
